//--- exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data path and PC width of the core
`define XLEN        32

// Multiplier step counter, wide enough to hold XLEN itself
`define MUL_CNT_W   6

// Exception request code sent to the exception unit
`define EXC_CODE_W  4

// Internal request code for mret, the exception unit maps it to its own action
`define EXC_MRET    4'd3

`endif

//--- exec_pkg.sv
package exec_pkg;

    // Operand source for both ALU inputs
    typedef enum logic [2:0] {
        OP_SEL_NONE = 3'd0,
        OP_SEL_RS1  = 3'd1,
        OP_SEL_RS2  = 3'd2,
        OP_SEL_IMM  = 3'd3,
        OP_SEL_CSR  = 3'd4,
        OP_SEL_PC   = 3'd5
    } operand_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10 // Second operand straight through, used by lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_op_e;

    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_OP1  = 3'd1,
        WB_LINK = 3'd2,
        WB_CSR  = 3'd3,
        WB_MUL  = 3'd4
    } wb_sel_e;

    typedef enum logic [1:0] {CSR_NONE = 2'd0, CSR_RW = 2'd1, CSR_RS = 2'd2, CSR_MRET = 2'd3} csr_op_e;

    typedef enum logic [1:0] {MOP_NONE = 2'd0, MOP_MUL = 2'd1, MOP_MULHU = 2'd2} mul_op_e;

    typedef enum logic [1:0] {MS_IDLE = 2'd0, MS_RUN = 2'd1, MS_DONE = 2'd2} mul_state_e;

endpackage

//--- alu.sv
`timescale 1ns/10ps

`include "exec_consts.svh"

module alu import exec_pkg::*; (
    input  alu_op_e             op_i,
    input  logic [`XLEN-1:0]    a_i,
    input  logic [`XLEN-1:0]    b_i,
    output logic [`XLEN-1:0]    result_o,
    output logic                eq_o,
    output logic                lt_o,
    output logic                ltu_o
);

    logic [4:0]         shamt;
    logic [`XLEN-1:0]   sum;
    logic [`XLEN-1:0]   diff;

    assign shamt = b_i[4:0]; // Only the low five bits count for RV32 shifts
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    // Flags come from the same operands so the branch unit can use them directly
    assign eq_o  = (a_i == b_i);
    assign lt_o  = ($signed(a_i) < $signed(b_i));
    assign ltu_o = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = sum;
            end
            ALU_SUB: begin
                result_o = diff;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt); // Keeps the sign bit
            end
            ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_o};
            end
            ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, ltu_o};
            end
            ALU_PASS2: begin
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- branch_unit.sv
`timescale 1ns/10ps

`include "exec_consts.svh"

module branch_unit import exec_pkg::*; (
    input  branch_op_e          op_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`XLEN-1:0]    rs1_i,
    input  logic                taken_i,
    input  logic                eq_i,
    input  logic                lt_i,
    input  logic                ltu_i,
    output logic                redirect_valid_o,
    output logic [`XLEN-1:0]    redirect_pc_o,
    output logic                fb_update_o,
    output logic                fb_taken_o,
    output logic                fb_mispredict_o,
    output logic [`XLEN-1:0]    link_pc_o
);

    logic               is_branch;
    logic               is_jalr;
    logic               actual_taken;
    logic [`XLEN-1:0]   pc_plus4;
    logic [`XLEN-1:0]   jalr_sum;
    logic [`XLEN-1:0]   target;

    always_comb begin
        case (op_i)
            BR_BEQ:          actual_taken = eq_i;
            BR_BNE:          actual_taken = !eq_i;
            BR_BLT:          actual_taken = lt_i;
            BR_BGE:          actual_taken = !lt_i;
            BR_BLTU:         actual_taken = ltu_i;
            BR_BGEU:         actual_taken = !ltu_i;
            BR_JAL, BR_JALR: actual_taken = 1'b1;
            default:         actual_taken = 1'b0;
        endcase
    end

    assign is_branch = (op_i != BR_NONE);
    assign is_jalr   = (op_i == BR_JALR);

    assign pc_plus4 = pc_i + `XLEN'd4;
    assign jalr_sum = rs1_i + imm_i;
    assign target   = is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign fb_mispredict_o = is_branch && (actual_taken != taken_i);

    // The predictor never knows the jalr target, so it always goes back to fetch
    assign redirect_valid_o = fb_mispredict_o || is_jalr;
    assign redirect_pc_o    = actual_taken ? target : pc_plus4;

    assign fb_update_o = is_branch;
    assign fb_taken_o  = actual_taken;
    assign link_pc_o   = pc_plus4;

endmodule

//--- mul_unit.sv
`timescale 1ns/10ps

`include "exec_consts.svh"

module mul_unit import exec_pkg::*; (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  mul_op_e             op_i,
    input  logic [`XLEN-1:0]    a_i,
    input  logic [`XLEN-1:0]    b_i,
    input  logic                hold_i,
    output logic [`XLEN-1:0]    product_o,
    output logic                done_o
);

    mul_state_e             state_q;
    logic [`MUL_CNT_W-1:0]  cnt_q;
    logic [2*`XLEN-1:0]     acc_q;
    logic [2*`XLEN-1:0]     mcand_q;
    logic [`XLEN-1:0]       mplier_q;
    mul_op_e                op_q;

    // Control state
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= MS_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MS_IDLE: begin
                    if (start_i) begin
                        state_q <= MS_RUN;
                        cnt_q   <= `MUL_CNT_W'(`XLEN);
                    end
                end
                MS_RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == `MUL_CNT_W'd1) begin
                        state_q <= MS_DONE; // Last multiplier bit handled this cycle
                    end
                end
                MS_DONE: begin
                    if (!hold_i) begin
                        state_q <= MS_IDLE; // Result taken by the pipeline register
                    end
                end
                default: begin
                    state_q <= MS_IDLE;
                end
            endcase
        end
    end

    // Operands and accumulator
    always_ff @(posedge clk_i) begin
        if (state_q == MS_IDLE && start_i) begin
            acc_q    <= '0;
            mcand_q  <= {{`XLEN{1'b0}}, a_i};
            mplier_q <= b_i;
            op_q     <= op_i;
        end else if (state_q == MS_RUN) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign done_o    = (state_q == MS_DONE);
    assign product_o = (op_q == MOP_MULHU) ? acc_q[2*`XLEN-1:`XLEN] : acc_q[`XLEN-1:0];

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

`include "exec_consts.svh"

module exec_unit import exec_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    hold_i,

    input  logic                    uop_valid_i,
    input  logic [`XLEN-1:0]        uop_pc_i,
    input  logic [`XLEN-1:0]        uop_rs1_i,
    input  logic [`XLEN-1:0]        uop_rs2_i,
    input  logic [`XLEN-1:0]        uop_imm_i,
    input  logic [`XLEN-1:0]        uop_csr_i,
    input  logic [4:0]              uop_rd_i,
    input  logic                    uop_taken_i,
    input  operand_sel_e            uop_op1_sel_i,
    input  operand_sel_e            uop_op2_sel_i,
    input  alu_op_e                 uop_alu_op_i,
    input  branch_op_e              uop_branch_op_i,
    input  wb_sel_e                 uop_wb_sel_i,
    input  csr_op_e                 uop_csr_op_i,
    input  mul_op_e                 uop_mul_op_i,

    output logic                    stall_o,
    output logic                    flush_o,
    output logic                    redirect_valid_o,
    output logic [`XLEN-1:0]        redirect_pc_o,
    output logic [`XLEN-1:0]        fb_pc_o,
    output logic                    fb_update_o,
    output logic                    fb_taken_o,
    output logic                    fb_mispredict_o,
    output logic                    exc_valid_o,
    output logic [`XLEN-1:0]        exc_pc_o,
    output logic [`EXC_CODE_W-1:0]  exc_code_o,

    output logic                    mem_valid_o,
    output logic [`XLEN-1:0]        mem_pc_o,
    output logic [4:0]              mem_rd_o,
    output logic [`XLEN-1:0]        mem_result_o,
    output logic [`XLEN-1:0]        mem_csr_o
);

    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   alu_result;
    logic               alu_eq;
    logic               alu_lt;
    logic               alu_ltu;

    logic               br_redirect;
    logic [`XLEN-1:0]   br_redirect_pc;
    logic               br_update;
    logic               br_taken;
    logic               br_mispredict;
    logic [`XLEN-1:0]   br_link_pc;

    logic               is_mul;
    logic               mul_start;
    logic               mul_done;
    logic               mul_active_q;
    logic [`XLEN-1:0]   mul_product;

    logic               is_mret;
    logic [`XLEN-1:0]   wb_value;
    logic [`XLEN-1:0]   csr_value;

    logic               mem_valid_q;
    logic [`XLEN-1:0]   mem_pc_q;
    logic [4:0]         mem_rd_q;
    logic [`XLEN-1:0]   mem_result_q;
    logic [`XLEN-1:0]   mem_csr_q;

    function automatic logic [`XLEN-1:0] sel_operand(
        input operand_sel_e     sel,
        input logic [`XLEN-1:0] rs1,
        input logic [`XLEN-1:0] rs2,
        input logic [`XLEN-1:0] imm,
        input logic [`XLEN-1:0] csr,
        input logic [`XLEN-1:0] pc
    );
        case (sel)
            OP_SEL_RS1: return rs1;
            OP_SEL_RS2: return rs2;
            OP_SEL_IMM: return imm;
            OP_SEL_CSR: return csr;
            OP_SEL_PC:  return pc;
            default:    return '0;
        endcase
    endfunction

    assign op1 = sel_operand(uop_op1_sel_i, uop_rs1_i, uop_rs2_i, uop_imm_i, uop_csr_i, uop_pc_i);
    assign op2 = sel_operand(uop_op2_sel_i, uop_rs1_i, uop_rs2_i, uop_imm_i, uop_csr_i, uop_pc_i);

    alu u_alu (
        .op_i       (uop_alu_op_i),
        .a_i        (op1),
        .b_i        (op2),
        .result_o   (alu_result),
        .eq_o       (alu_eq),
        .lt_o       (alu_lt),
        .ltu_o      (alu_ltu)
    );

    branch_unit u_branch_unit (
        .op_i               (uop_branch_op_i),
        .pc_i               (uop_pc_i),
        .imm_i              (uop_imm_i),
        .rs1_i              (uop_rs1_i),
        .taken_i            (uop_taken_i),
        .eq_i               (alu_eq),
        .lt_i               (alu_lt),
        .ltu_i              (alu_ltu),
        .redirect_valid_o   (br_redirect),
        .redirect_pc_o      (br_redirect_pc),
        .fb_update_o        (br_update),
        .fb_taken_o         (br_taken),
        .fb_mispredict_o    (br_mispredict),
        .link_pc_o          (br_link_pc)
    );

    assign is_mul    = (uop_mul_op_i != MOP_NONE);
    assign mul_start = uop_valid_i && is_mul && !mul_active_q; // One pulse per multiply

    mul_unit u_mul_unit (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (mul_start),
        .op_i       (uop_mul_op_i),
        .a_i        (uop_rs1_i),
        .b_i        (uop_rs2_i),
        .hold_i     (hold_i),
        .product_o  (mul_product),
        .done_o     (mul_done)
    );

    // Set by the start pulse and cleared once the product has been registered
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mul_active_q <= 1'b0;
        end else if (mul_start) begin
            mul_active_q <= 1'b1;
        end else if (mul_done && !hold_i) begin
            mul_active_q <= 1'b0;
        end
    end

    always_comb begin
        case (uop_wb_sel_i)
            WB_OP1:  wb_value = op1;
            WB_LINK: wb_value = br_link_pc;
            WB_CSR:  wb_value = uop_csr_i;   // Old CSR value goes to rd
            WB_MUL:  wb_value = mul_product;
            default: wb_value = alu_result;
        endcase

        case (uop_csr_op_i)
            CSR_RW:  csr_value = uop_rs1_i;
            CSR_RS:  csr_value = alu_result; // Decode sets the ALU to or csr with rs1
            default: csr_value = '0;
        endcase
    end

    assign is_mret = (uop_csr_op_i == CSR_MRET);

    assign stall_o          = uop_valid_i && is_mul && !mul_done;
    assign flush_o          = uop_valid_i && br_mispredict;
    assign redirect_valid_o = uop_valid_i && br_redirect;
    assign redirect_pc_o    = br_redirect_pc;
    assign fb_pc_o          = uop_pc_i;
    assign fb_update_o      = uop_valid_i && br_update;
    assign fb_taken_o       = br_taken;
    assign fb_mispredict_o  = uop_valid_i && br_mispredict;
    assign exc_valid_o      = uop_valid_i && is_mret;
    assign exc_pc_o         = uop_pc_i;
    assign exc_code_o       = is_mret ? `EXC_MRET : '0;

    // Execute/memory register, a bubble goes in while the multiplier is busy
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mem_valid_q <= 1'b0;
        end else if (!hold_i) begin
            mem_valid_q <= uop_valid_i && !stall_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            mem_pc_q     <= uop_pc_i;
            mem_rd_q     <= uop_rd_i;
            mem_result_q <= wb_value;
            mem_csr_q    <= csr_value;
        end
    end

    assign mem_valid_o  = mem_valid_q;
    assign mem_pc_o     = mem_pc_q;
    assign mem_rd_o     = mem_rd_q;
    assign mem_result_o = mem_result_q;
    assign mem_csr_o    = mem_csr_q;

endmodule

//--- tb_exec_unit.sv
`timescale 1ns/10ps

`include "exec_consts.svh"

module tb_exec_unit import exec_pkg::*; ();

    logic clk_i, rstn_i, hold_i, uop_valid_i, uop_taken_i;
    logic [31:0] uop_pc_i, uop_rs1_i, uop_rs2_i, uop_imm_i, uop_csr_i;
    logic [4:0] uop_rd_i;
    operand_sel_e uop_op1_sel_i, uop_op2_sel_i;
    alu_op_e uop_alu_op_i;
    branch_op_e uop_branch_op_i;
    wb_sel_e uop_wb_sel_i;
    csr_op_e uop_csr_op_i;
    mul_op_e uop_mul_op_i;
    logic stall_o, flush_o, redirect_valid_o, fb_update_o, fb_taken_o, fb_mispredict_o;
    logic exc_valid_o, mem_valid_o;
    logic [31:0] redirect_pc_o, fb_pc_o, exc_pc_o, mem_pc_o, mem_result_o, mem_csr_o;
    logic [3:0] exc_code_o;
    logic [4:0] mem_rd_o;

    integer errors;
    integer fd;
    logic timed_out;
    logic [31:0] f [0:21];

    exec_unit dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    // Runs one micro-op from presentation until the register has taken it
    task automatic run_vector(input integer n);
        string tag;
        integer cycles;
        integer hold_left;
        logic consumed;
        logic bubble_loaded;
        logic [31:0] snap_pc, snap_res, snap_csr;
        logic [4:0] snap_rd;
        logic snap_valid;
        logic is_mul;
        logic is_branch;
        tag = $sformatf("vec%0d", n);
        hold_left = f[15];
        is_mul = (f[14] != 0);
        is_branch = (f[11] != 0);
        @(posedge clk_i);
        uop_valid_i     <= f[0][0];
        uop_pc_i        <= f[1];
        uop_rs1_i       <= f[2];
        uop_rs2_i       <= f[3];
        uop_imm_i       <= f[4];
        uop_csr_i       <= f[5];
        uop_rd_i        <= f[6][4:0];
        uop_taken_i     <= f[7][0];
        uop_op1_sel_i   <= operand_sel_e'(f[8][2:0]);
        uop_op2_sel_i   <= operand_sel_e'(f[9][2:0]);
        uop_alu_op_i    <= alu_op_e'(f[10][3:0]);
        uop_branch_op_i <= branch_op_e'(f[11][3:0]);
        uop_wb_sel_i    <= wb_sel_e'(f[12][2:0]);
        uop_csr_op_i    <= csr_op_e'(f[13][1:0]);
        uop_mul_op_i    <= mul_op_e'(f[14][1:0]);
        hold_i          <= (hold_left > 0);

        // Combinational outputs in the cycle the op is presented
        @(negedge clk_i);
        check({tag, "_redirect_valid"}, f[18], redirect_valid_o);
        if (f[18][0]) begin
            check({tag, "_redirect_pc"}, f[19], redirect_pc_o);
        end
        check({tag, "_flush"}, f[20], flush_o);
        check({tag, "_mispredict"}, f[20], fb_mispredict_o);
        check({tag, "_fb_update"}, is_branch, fb_update_o);
        if (is_branch) begin
            check({tag, "_fb_pc"}, f[1], fb_pc_o);
            // The real outcome differs from the prediction exactly on a mispredict
            check({tag, "_fb_taken"}, f[7][0] ^ f[20][0], fb_taken_o);
        end
        check({tag, "_exc_valid"}, f[21], exc_valid_o);
        if (f[21][0]) begin
            check({tag, "_exc_code"}, `EXC_MRET, exc_code_o);
            check({tag, "_exc_pc"}, f[1], exc_pc_o);
        end
        check({tag, "_stall"}, is_mul, stall_o);
        snap_valid = mem_valid_o;
        snap_pc = mem_pc_o;
        snap_rd = mem_rd_o;
        snap_res = mem_result_o;
        snap_csr = mem_csr_o;

        cycles = 0;
        consumed = 1'b0;
        bubble_loaded = 1'b0;
        while (!consumed && cycles < 100) begin
            if (cycles > 0) begin
                @(negedge clk_i);
            end
            if (hold_i) begin
                check({tag, "_hold_valid"}, snap_valid, mem_valid_o);
                check({tag, "_hold_pc"}, snap_pc, mem_pc_o);
                check({tag, "_hold_rd"}, snap_rd, mem_rd_o);
                check({tag, "_hold_result"}, snap_res, mem_result_o);
                check({tag, "_hold_csr"}, snap_csr, mem_csr_o);
            end else if (bubble_loaded) begin
                check({tag, "_bubble"}, 1'b0, mem_valid_o);
            end
            if (!hold_i && !stall_o) begin
                consumed = 1'b1;
            end else begin
                bubble_loaded = stall_o && !hold_i; // The next edge loads a bubble
                @(posedge clk_i);
                if (hold_left > 0) begin
                    hold_left = hold_left - 1;
                end
                if (hold_left == 0) begin
                    hold_i <= 1'b0;
                end
                cycles = cycles + 1;
            end
        end
        if (!consumed) begin
            $display("ERROR: %s was not taken by the register within 100 cycles", tag);
            errors = errors + 1;
            timed_out = 1'b1;
        end else begin
            @(posedge clk_i);
            uop_valid_i <= 1'b0; // Retire the op so it is not loaded twice
            @(negedge clk_i);
            check({tag, "_mem_valid"}, 1'b1, mem_valid_o);
            check({tag, "_mem_pc"}, f[1], mem_pc_o);
            check({tag, "_mem_rd"}, f[6][4:0], mem_rd_o);
            check({tag, "_mem_result"}, f[16], mem_result_o);
            check({tag, "_mem_csr"}, f[17], mem_csr_o);
        end
    endtask

    initial begin
        string line;
        integer n;
        integer cnt;
        errors = 0;
        timed_out = 1'b0;
        rstn_i = 1'b0;
        hold_i = 1'b1; // Register only leaves X through its reset
        uop_valid_i = 1'b0;
        uop_pc_i = '0;
        uop_rs1_i = '0;
        uop_rs2_i = '0;
        uop_imm_i = '0;
        uop_csr_i = '0;
        uop_rd_i = '0;
        uop_taken_i = 1'b0;
        uop_op1_sel_i = OP_SEL_NONE;
        uop_op2_sel_i = OP_SEL_NONE;
        uop_alu_op_i = ALU_ADD;
        // Jalr, mret and multiply fields with valid low must keep every control output low
        uop_branch_op_i = BR_JALR;
        uop_wb_sel_i = WB_ALU;
        uop_csr_op_i = CSR_MRET;
        uop_mul_op_i = MOP_MUL;

        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check("reset_mem_valid", 1'b0, mem_valid_o);
        check("reset_stall", 1'b0, stall_o);
        check("reset_flush", 1'b0, flush_o);
        check("reset_redirect", 1'b0, redirect_valid_o);
        check("reset_fb_update", 1'b0, fb_update_o);
        check("reset_exc_valid", 1'b0, exc_valid_o);

        n = 0;
        fd = $fopen("exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open exec_stimulus.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                        f[21]);
                    if (cnt == 22) begin
                        n = n + 1;
                        run_vector(n);
                    end
                end
            end
            $fclose(fd);
            if (n == 0) begin
                $display("ERROR: no vectors were read from the stimulus file");
                errors = errors + 1;
            end
        end

        $display("Vectors run %0d, errors %0d", n, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
exec_pkg.sv
alu.sv
branch_unit.sv
mul_unit.sv
exec_unit.sv
tb_exec_unit.sv

//--- exec_stimulus.txt
# v pc rs1 rs2 imm csr rd taken op1_sel op2_sel alu_op br_op wb_sel csr_op mul_op hold_cycles
# then expected: result csr redirect_valid redirect_pc mispredict exc_valid (all hex)
1 00000100 00000005 00000007 00000000 00000000 01 0 1 2 0 0 0 0 0 0 0000000c 00000000 0 00000000 0 0
1 00000104 00000010 00000000 00000003 00000000 02 0 1 3 1 0 0 0 0 0 0000000d 00000000 0 00000000 0 0
1 00000108 f0f0f0f0 ff00ff00 00000000 00000000 03 0 1 2 2 0 0 0 0 0 f000f000 00000000 0 00000000 0 0
1 0000010c 12340000 00000000 00005678 00000000 04 0 1 3 3 0 0 0 0 0 12345678 00000000 0 00000000 0 0
1 00000110 00000000 aaaaaaaa 00000000 ffffffff 05 0 2 4 4 0 0 0 0 0 55555555 00000000 0 00000000 0 0
1 00000114 00000001 00000024 00000000 00000000 06 0 1 2 5 0 0 0 0 0 00000010 00000000 0 00000000 0 0
1 00000118 80000000 00000000 0000001f 00000000 07 0 1 3 6 0 0 0 0 0 00000001 00000000 0 00000000 0 0
1 0000011c 80000000 00000000 00000004 00000000 08 0 1 3 7 0 0 0 0 0 f8000000 00000000 0 00000000 0 0
1 00000120 ffffffff 00000001 00000000 00000000 09 0 1 2 8 0 0 0 0 0 00000001 00000000 0 00000000 0 0
1 00000124 ffffffff 00000001 00000000 00000000 0a 0 1 2 9 0 0 0 0 0 00000000 00000000 0 00000000 0 0
1 00001000 00000000 00000000 00002000 00000000 0b 0 5 3 0 0 0 0 0 0 00003000 00000000 0 00000000 0 0
1 00000128 00000000 00000000 deadb000 00000000 0c 0 0 3 a 0 0 0 0 0 deadb000 00000000 0 00000000 0 0
1 0000012c 00000000 00000000 00000000 00000abc 0d 0 4 0 0 0 1 0 0 0 00000abc 00000000 0 00000000 0 0
1 00000200 00000005 00000005 00000040 00000000 00 1 1 2 1 1 0 0 0 0 00000000 00000000 0 00000000 0 0
1 00000204 00000005 00000005 00000040 00000000 00 0 1 2 1 2 0 0 0 0 00000000 00000000 0 00000000 0 0
1 00000300 ffffffff 00000001 00000020 00000000 00 0 1 2 1 3 0 0 0 0 fffffffe 00000000 1 00000320 1 0
1 00000400 ffffffff 00000001 00000020 00000000 00 1 1 2 1 4 0 0 0 0 fffffffe 00000000 1 00000404 1 0
1 00000440 00000001 ffffffff 00000020 00000000 00 1 1 2 1 5 0 0 0 0 00000002 00000000 0 00000000 0 0
1 00000500 00000001 ffffffff 00000020 00000000 00 1 1 2 1 6 0 0 0 0 00000002 00000000 1 00000504 1 0
1 00000600 00000000 00000000 00000100 00000000 01 1 0 0 0 7 2 0 0 0 00000604 00000000 0 00000000 0 0
1 00000700 00001003 00000000 00000004 00000000 01 1 1 3 0 8 2 0 0 0 00000704 00000000 1 00001006 0 0
1 00000800 00000000 00000000 fffffff0 00000000 01 0 0 0 0 7 2 0 0 0 00000804 00000000 1 000007f0 1 0
1 00000900 11111111 00000000 00000000 22222222 0e 0 1 0 0 0 3 1 0 0 22222222 11111111 0 00000000 0 0
1 00000904 0000000f 00000000 00000000 000000f0 0f 0 4 1 3 0 3 2 0 0 000000f0 000000ff 0 00000000 0 0
1 00000908 00000000 00000000 00000000 00000000 00 0 0 0 0 0 0 3 0 0 00000000 00000000 0 00000000 0 1
1 00000a00 00012345 00006789 00000000 00000000 10 0 0 0 0 0 4 0 1 0 75cca2ed 00000000 0 00000000 0 0
1 00000a04 ffffffff ffffffff 00000000 00000000 11 0 0 0 0 0 4 0 2 0 fffffffe 00000000 0 00000000 0 0
1 00000a08 ffffffff ffffffff 00000000 00000000 12 0 0 0 0 0 4 0 1 28 00000001 00000000 0 00000000 0 0
1 00000a0c 00000001 00000002 00000000 00000000 13 0 1 2 0 0 0 0 0 5 00000003 00000000 0 00000000 0 0
